// ==== vlog.f ====
flacRicePkg.sv
bitPairFeeder.sv
riceStreamReader.sv
residualUnfolder.sv
riceResidualDecoder.sv
riceDecoderProperties_properties.sv
tbResidualChecker.sv
tbRiceResidualDecoder.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tbRiceResidualDecoder -o simRice > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/simRice > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

exit 0

// ==== tbRiceResidualDecoder.sv ====
`timescale 1ns/10ps

module tbRiceResidualDecoder;

    import flacRicePkg::*;

    localparam int residualWidth = defaultResidualWidth;
    localparam int numTests = 8;
    localparam int resetCycles = 8;
    localparam int numFixed = 38;
    localparam int srcFixed = 0;
    localparam int srcRandom = 1;
    localparam int drainLimit = 400;

    logic                              iClock;
    logic                              reset;
    logic                              iLoad;
    logic [wordWidth-1:0]              iWord;
    logic [paramWidth-1:0]             iRiceParam;
    logic [blockCountWidth-1:0]        iBlockSize;
    logic                              oReady;
    logic signed [residualWidth-1:0]   oResidual;
    logic                              oResidualValid;
    logic                              oBlockDone;

    // One row per test. A parameter of 0 means a random parameter.
    int testParam [numTests];
    int testSize [numTests];
    int testSource [numTests];
    int testStart [numTests];  // First entry in fixedResiduals.
    bit testGaps [numTests];
    bit testReset [numTests];
    int fixedResiduals [numFixed];

    int seed;
    int residuals [$];
    logic [wordWidth-1:0] words [$];
    bit tableReady;
    int limitCycles;

    riceResidualDecoder #(
        .residualWidth (residualWidth)
    ) dut0 (
        .iClock         (iClock),
        .reset          (reset),
        .iLoad          (iLoad),
        .iWord          (iWord),
        .oReady         (oReady),
        .iRiceParam     (iRiceParam),
        .iBlockSize     (iBlockSize),
        .oResidual      (oResidual),
        .oResidualValid (oResidualValid),
        .oBlockDone     (oBlockDone)
    );

    tbResidualChecker #(
        .residualWidth (residualWidth)
    ) checker0 (
        .iClock        (iClock),
        .reset         (reset),
        .residual      (oResidual),
        .residualValid (oResidualValid),
        .blockDone     (oBlockDone)
    );

    always #5 iClock = ~iClock;

    task automatic setTest(input int idx, input int k, input int size, input int source,
                           input int start, input bit gaps, input bit midReset);
        testParam[idx] = k;
        testSize[idx] = size;
        testSource[idx] = source;
        testStart[idx] = start;
        testGaps[idx] = gaps;
        testReset[idx] = midReset;
    endtask

    task automatic fillTable();
        // Zeros, then large values, then a mix of empty and long runs, then wide values.
        fixedResiduals = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                           100, -100, 255, -256, 24, -37, 0, -1,
                           0, -1, 1, 5, -6, 0, 13, -14, 2, 0,
                           0, 40000, -40000, 1, -1, 70000, -65536, 3};
        setTest(0, 2, 12, srcFixed, 0, 1'b0, 1'b0);
        setTest(1, 4, 8, srcFixed, 12, 1'b0, 1'b0);
        setTest(2, 3, 10, srcFixed, 20, 1'b0, 1'b0);
        setTest(3, 5, 8, srcFixed, 12, 1'b0, 1'b0);
        setTest(4, 15, 8, srcFixed, 30, 1'b0, 1'b0);
        setTest(5, 0, 20, srcRandom, 0, 1'b0, 1'b0);
        setTest(6, 0, 24, srcRandom, 0, 1'b1, 1'b0);
        setTest(7, 6, 16, srcRandom, 0, 1'b0, 1'b1);
        tableReady = 1'b1;
    endtask

    // Folds each residual and writes quotient zeros, a one and k remainder bits.
    // The last word is padded with ones, which decode as codes past the end of the block.
    task automatic encodeBlock(input int k);
        int folded;
        int quotient;
        bit bits [$];
        logic [wordWidth-1:0] w;
        words.delete();
        foreach (residuals[i]) begin
            folded = (residuals[i] >= 0) ? 2 * residuals[i] : -2 * residuals[i] - 1;
            quotient = folded >> k;
            repeat (quotient) bits.push_back(1'b0);
            bits.push_back(1'b1);
            for (int b = k - 1; b >= 0; b--) begin
                bits.push_back(folded[b]);
            end
        end
        while (bits.size() % wordWidth != 0) bits.push_back(1'b1);
        for (int i = 0; i < bits.size(); i += wordWidth) begin
            w = '0;
            for (int j = 0; j < wordWidth; j++) begin
                w[wordWidth-1-j] = bits[i+j];  // First bit of the stream is the MSB.
            end
            words.push_back(w);
        end
    endtask

    task automatic makeRandom(input int count, input int k);
        residuals.delete();
        repeat (count) residuals.push_back($random(seed) % (1 << (k + 1)));
    endtask

    task automatic applyReset();
        reset = 1'b1;
        iLoad = 1'b0;
        repeat (resetCycles) begin
            @(posedge iClock);
            #1;
        end
        reset = 1'b0;
    endtask

    task automatic loadWords(input bit gaps);
        int idle;
        foreach (words[i]) begin
            while (!oReady) begin
                @(posedge iClock);
                #1;
            end
            // Idle cycles here let the feeder run dry, so the reader stalls mid-code.
            if (gaps) begin
                idle = $unsigned($random(seed)) % 5;
                repeat (idle) begin
                    @(posedge iClock);
                    #1;
                end
            end
            iWord = words[i];
            iLoad = 1'b1;
            @(posedge iClock);
            #1;
            iLoad = 1'b0;
        end
    endtask

    // Starts a long block and cuts it short. Its outputs are not compared.
    task automatic abortedBlock();
        iRiceParam = 4'd9;
        iBlockSize = 16'd50;
        applyReset();
        checker0.setIgnore(1'b1);
        makeRandom(30, 9);
        encodeBlock(9);
        while (words.size() > 3) void'(words.pop_back());
        loadWords(1'b0);
        repeat (4) begin
            @(posedge iClock);
            #1;
        end
    endtask

    task automatic runTest(input int t);
        int k;
        int waited;
        if (testReset[t]) begin
            abortedBlock();
        end
        k = testParam[t];
        if (k == 0) begin
            k = 2 + ($unsigned($random(seed)) % 14);
        end
        if (testSource[t] == srcFixed) begin
            residuals.delete();
            for (int i = 0; i < testSize[t]; i++) begin
                residuals.push_back(fixedResiduals[testStart[t] + i]);
            end
        end else begin
            makeRandom(testSize[t], k);
        end
        encodeBlock(k);
        iRiceParam = k[paramWidth-1:0];
        iBlockSize = testSize[t][blockCountWidth-1:0];
        applyReset();
        checker0.setIgnore(1'b0);
        checker0.startTest(t, k);
        foreach (residuals[i]) checker0.pushExpected(residuals[i]);
        loadWords(testGaps[t]);
        waited = 0;
        while (checker0.pendingCount() > 0 && waited < drainLimit) begin
            @(posedge iClock);
            #1;
            waited++;
        end
        // Long enough for the rest of the last word to reach the output.
        repeat (12) begin
            @(posedge iClock);
            #1;
        end
        checker0.finishTest();
    endtask

    // Each residual takes at most three words here, and a word at most 20 cycles.
    initial begin
        wait (tableReady);
        limitCycles = 1000 + 100;
        for (int t = 0; t < numTests; t++) begin
            limitCycles += (testSize[t] * 3 + 1) * 20 + resetCycles + 20;
        end
        repeat (limitCycles) @(posedge iClock);
        $display("Watchdog: the run did not finish within %0d cycles", limitCycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed = 20865;
        iClock = 1'b0;
        reset = 1'b1;
        iLoad = 1'b0;
        iWord = '0;
        iRiceParam = 4'd2;
        iBlockSize = '0;
        tableReady = 1'b0;
        fillTable();
        @(posedge iClock);
        #1;
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests run: %0d, residuals checked: %0d, errors: %0d",
                 numTests, checker0.checkedCount, checker0.errorCount);
        if (checker0.errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tbResidualChecker.sv ====
`timescale 1ns/10ps

module tbResidualChecker #(
    parameter int residualWidth = flacRicePkg::defaultResidualWidth
) (
    input logic                             iClock,
    input logic                             reset,
    input logic signed [residualWidth-1:0]  residual,
    input logic                             residualValid,
    input logic                             blockDone
);

    int expectedQueue [$];
    int errorCount = 0;
    int checkedCount = 0;
    int testErrors;
    int testIndex;
    int testParam;
    int testCount;
    int got;
    int want;
    bit ignoreOutput = 1'b0;
    bit blockSeen;

    task automatic reportProblem(input string text);
        $display("ERROR at time %0t: %s", $time, text);
        errorCount++;
        testErrors++;
    endtask

    task automatic setIgnore(input bit value);
        ignoreOutput = value;
    endtask

    task automatic startTest(input int idx, input int k);
        expectedQueue.delete();
        testIndex = idx;
        testParam = k;
        testErrors = 0;
        testCount = 0;
        blockSeen = 1'b0;
    endtask

    task automatic pushExpected(input int value);
        expectedQueue.push_back(value);
    endtask

    function automatic int pendingCount();
        return expectedQueue.size();
    endfunction

    task automatic finishTest();
        if (expectedQueue.size() > 0) begin
            reportProblem($sformatf("%0d expected residuals never came out",
                                    expectedQueue.size()));
        end
        if (!blockSeen) begin
            reportProblem("the block done pulse never came");
        end
        $display("Test %0d (parameter %0d): %s, %0d residuals checked", testIndex, testParam,
                 (testErrors == 0) ? "passed" : "FAILED", testCount);
        expectedQueue.delete();
    endtask

    always @(posedge iClock) begin
        if (!reset && !ignoreOutput) begin
            if (blockDone && !residualValid) begin
                reportProblem("block done pulse came without a residual");
            end
            if (residualValid) begin
                got = residual;  // Sign extended to 32 bits.
                if (blockSeen) begin
                    reportProblem($sformatf("residual %0d came after the end of the block", got));
                end else if (expectedQueue.size() == 0) begin
                    reportProblem($sformatf("an extra residual %0d came out", got));
                end else begin
                    want = expectedQueue.pop_front();
                    checkedCount++;
                    testCount++;
                    if (got != want) begin
                        $display("FAIL at time %0t: residual %0d expected %0d, got %0d",
                                 $time, testCount, want, got);
                        errorCount++;
                        testErrors++;
                    end
                    if (blockDone != (expectedQueue.size() == 0)) begin
                        reportProblem("block done did not line up with the last residual");
                    end
                end
                if (blockDone) begin
                    blockSeen = 1'b1;
                end
            end
        end
    end

endmodule

// ==== riceDecoderProperties_properties.sv ====
`timescale 1ns/10ps

module riceDecoderProperties (
    input logic iClock,
    input logic reset,
    input logic done,
    input logic oResidualValid,
    input logic oBlockDone,
    input logic oReady
);

    // Every residual comes from a reader done one cycle before.
    validAfterDone: assert property (@(posedge iClock) disable iff (reset)
        oResidualValid |-> $past(done))
        else $error("residual valid without a reader done in the cycle before");

    blockDoneWithValid: assert property (@(posedge iClock)
        oBlockDone |-> oResidualValid)
        else $error("block done without a residual");

    readyAfterReset: assert property (@(posedge iClock)
        $fell(reset) |-> oReady)
        else $error("feeder not ready in the first cycle after reset");

    quietInReset: assert property (@(posedge iClock)
        reset |=> (!oResidualValid && !oBlockDone && !done))
        else $error("valid output while reset is held");

endmodule

bind riceResidualDecoder riceDecoderProperties props0 (
    .iClock         (iClock),
    .reset          (reset),
    .done           (done),
    .oResidualValid (oResidualValid),
    .oBlockDone     (oBlockDone),
    .oReady         (oReady)
);

// ==== riceResidualDecoder.sv ====
`timescale 1ns/10ps

module riceResidualDecoder #(
    parameter int residualWidth = flacRicePkg::defaultResidualWidth
) (
    input  logic                                    iClock,
    input  logic                                    reset,
    input  logic                                    iLoad,
    input  logic [flacRicePkg::wordWidth-1:0]       iWord,
    output logic                                    oReady,
    input  logic [flacRicePkg::paramWidth-1:0]      iRiceParam,
    input  logic [flacRicePkg::blockCountWidth-1:0] iBlockSize,
    output logic signed [residualWidth-1:0]         oResidual,
    output logic                                    oResidualValid,
    output logic                                    oBlockDone
);

    import flacRicePkg::*;

    logic [1:0]           pair;
    logic                 pairValid;  // Also stalls the reader between words.
    logic [partWidth-1:0] msb;
    logic [partWidth-1:0] lsb;
    logic                 done;

    bitPairFeeder feeder0 (
        .iClock     (iClock),
        .reset      (reset),
        .iLoad      (iLoad),
        .iWord      (iWord),
        .oReady     (oReady),
        .oPair      (pair),
        .oPairValid (pairValid)
    );

    riceStreamReader reader0 (
        .iClock     (iClock),
        .reset      (reset),
        .iEnable    (pairValid),
        .iData      (pair),
        .iRiceParam (iRiceParam),
        .oMsb       (msb),
        .oLsb       (lsb),
        .oDone      (done)
    );

    residualUnfolder #(
        .residualWidth (residualWidth)
    ) unfolder0 (
        .iClock         (iClock),
        .reset          (reset),
        .iDone          (done),
        .iMsb           (msb),
        .iLsb           (lsb),
        .iRiceParam     (iRiceParam),
        .iBlockSize     (iBlockSize),
        .oResidual      (oResidual),
        .oResidualValid (oResidualValid),
        .oBlockDone     (oBlockDone)
    );

endmodule

// ==== residualUnfolder.sv ====
`timescale 1ns/10ps

module residualUnfolder #(
    parameter int residualWidth = flacRicePkg::defaultResidualWidth
) (
    input  logic                                    iClock,
    input  logic                                    reset,
    input  logic                                    iDone,
    input  logic [flacRicePkg::partWidth-1:0]       iMsb,
    input  logic [flacRicePkg::partWidth-1:0]       iLsb,
    input  logic [flacRicePkg::paramWidth-1:0]      iRiceParam,
    input  logic [flacRicePkg::blockCountWidth-1:0] iBlockSize,
    output logic signed [residualWidth-1:0]         oResidual,
    output logic                                    oResidualValid,
    output logic                                    oBlockDone
);

    import flacRicePkg::*;

    logic [residualWidth-1:0]        folded;
    logic [residualWidth-1:0]        half;
    logic signed [residualWidth-1:0] unfolded;
    logic [blockCountWidth-1:0]      residualCount;
    logic [blockCountWidth-1:0]      nextCount;
    logic                            finished;  // Block complete, wait for reset.
    logic                            accept;
    logic                            blockComplete;

    // Folded value is the quotient above the remainder bits.
    // Odd values are negative: -(half + 1) is the same as the inverse of half.
    always_comb begin
        folded = (residualWidth'(iMsb) << iRiceParam) | residualWidth'(iLsb);
        half = folded >> 1;
        unfolded = folded[0] ? ~half : half;
    end

    assign accept = iDone && !finished;
    assign nextCount = residualCount + 1'b1;
    assign blockComplete = (nextCount == iBlockSize);

    always_ff @(posedge iClock) begin
        if (reset) begin
            oResidualValid <= 1'b0;
            oBlockDone <= 1'b0;
            residualCount <= '0;
            finished <= 1'b0;
        end else begin
            oResidualValid <= accept;
            oBlockDone <= accept && blockComplete;
            if (accept) begin
                residualCount <= nextCount;
                if (blockComplete) begin
                    finished <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (accept) begin
            oResidual <= unfolded;
        end
    end

endmodule

// ==== riceStreamReader.sv ====
`timescale 1ns/10ps

module riceStreamReader (
    input  logic                               iClock,
    input  logic                               reset,
    input  logic                               iEnable,
    input  logic [1:0]                         iData,
    input  logic [flacRicePkg::paramWidth-1:0] iRiceParam,
    output logic [flacRicePkg::partWidth-1:0]  oMsb,
    output logic [flacRicePkg::partWidth-1:0]  oLsb,
    output logic                               oDone
);

    import flacRicePkg::*;

    localparam logic stateUnary = 1'b0;
    localparam logic stateRemainder = 1'b1;

    logic                  state;
    logic [partWidth-1:0]  quotient;   // Zeros counted so far in this code.
    logic [partWidth-1:0]  procLsb;    // Remainder bits gathered so far.
    logic [paramWidth-1:0] remBits;    // Remainder bits still owed.
    logic                  codeEnds;
    logic [partWidth-1:0]  endLsb;

    // A code can only end in the remainder state, since the parameter is at least 2.
    // With one bit owed, the code ends on the first bit of the pair.
    always_comb begin
        codeEnds = 1'b0;
        endLsb = {procLsb[partWidth-3:0], iData};
        if (iEnable && state == stateRemainder) begin
            if (remBits == 2) begin
                codeEnds = 1'b1;
            end else if (remBits == 1) begin
                codeEnds = 1'b1;
                endLsb = {procLsb[partWidth-2:0], iData[1]};
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            state <= stateUnary;
            quotient <= '0;
            remBits <= '0;
            oDone <= 1'b0;
        end else begin
            oDone <= codeEnds;
            if (iEnable) begin
                case (state)
                    stateUnary: begin
                        if (iData == 2'b00) begin
                            quotient <= quotient + 2'd2;
                        end else if (iData == 2'b01) begin
                            // The one ends the run, remainder begins with the next pair.
                            quotient <= quotient + 1'b1;
                            remBits <= iRiceParam;
                            state <= stateRemainder;
                        end else begin
                            // Run ends on the first bit, the second is already remainder.
                            remBits <= iRiceParam - 1'b1;
                            state <= stateRemainder;
                        end
                    end
                    stateRemainder: begin
                        if (remBits > 2) begin
                            remBits <= remBits - 2'd2;
                        end else if (remBits == 2) begin
                            quotient <= '0;
                            state <= stateUnary;
                        end else if (iData[0]) begin
                            // Carried bit is a one, so the next code has an empty run.
                            quotient <= '0;
                            remBits <= iRiceParam;
                        end else begin
                            quotient <= 16'd1;  // Carried zero opens the next run.
                            state <= stateUnary;
                        end
                    end
                    default: state <= stateUnary;
                endcase
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (iEnable) begin
            if (codeEnds) begin
                oMsb <= quotient;
                oLsb <= endLsb;
            end
            if (state == stateUnary) begin
                procLsb <= iData[1] ? partWidth'(iData[0]) : '0;
            end else if (remBits > 2) begin
                procLsb <= {procLsb[partWidth-3:0], iData};
            end else begin
                procLsb <= '0;  // The next code starts with no remainder bits.
            end
        end
    end

endmodule

// ==== bitPairFeeder.sv ====
`timescale 1ns/10ps

module bitPairFeeder (
    input  logic                              iClock,
    input  logic                              reset,
    input  logic                              iLoad,
    input  logic [flacRicePkg::wordWidth-1:0] iWord,
    output logic                              oReady,
    output logic [1:0]                        oPair,
    output logic                              oPairValid
);

    import flacRicePkg::*;

    localparam int pairsPerWord = wordWidth / 2;
    localparam int countWidth = $clog2(pairsPerWord);
    localparam logic [countWidth-1:0] lastPair = countWidth'(pairsPerWord - 1);

    logic [wordWidth-1:0]  shiftReg;
    logic [countWidth-1:0] pairCount;  // Index of the pair on oPair.
    logic                  busy;
    logic                  takeWord;

    // A word can be taken when nothing is held or the last pair is on the output,
    // so back to back loads give one pair on every cycle.
    assign oReady = !busy || (pairCount == lastPair);
    assign takeWord = iLoad && oReady;

    assign oPair = shiftReg[wordWidth-1 -: 2];  // Top pair goes out first.
    assign oPairValid = busy;

    always_ff @(posedge iClock) begin
        if (reset) begin
            busy <= 1'b0;
            pairCount <= '0;
        end else if (takeWord) begin
            busy <= 1'b1;
            pairCount <= '0;
        end else if (busy) begin
            if (pairCount == lastPair) begin
                busy <= 1'b0;  // Word used up and nothing new arrived.
            end else begin
                pairCount <= pairCount + 1'b1;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (takeWord) begin
            shiftReg <= iWord;
        end else if (busy) begin
            shiftReg <= shiftReg << 2;
        end
    end

endmodule

// ==== flacRicePkg.sv ====
package flacRicePkg;

    // Width of one word of the coded bitstream, sent most significant bit first.
    localparam int wordWidth = 16;

    // The Rice parameter is fixed for a whole block; values 2 to 15 are supported.
    localparam int paramWidth = 4;

    // Width of the unary quotient and of the remainder.
    localparam int partWidth = 16;

    localparam int blockCountWidth = 16; // Block size and residual counter.

    // Signed residual width used when the top level sets nothing else.
    // The remainder has to fit below the sign, so 17 is the smallest usable width.
    localparam int defaultResidualWidth = 24;

endpackage
